// File: sim.f
source/ds_pkg.sv
source/window_buffer.sv
source/dw_conv.sv
source/pw_conv.sv
source/ds_block_top.sv
testbench/tb_ds_block.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the depthwise-separable block testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module tb_ds_block \
    -Mdir obj_dir \
    -f sim.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_ds_block)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Done: no errors"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// File: testbench/tb_ds_block.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ds_block;

    localparam int IMG_W = 6;
    localparam int IMG_H = 5;
    localparam int STRIDE = 1;
    localparam int ACT_W = ds_pkg::ACT_W;
    localparam int NCH = ds_pkg::NCH;
    localparam int NOUT = ds_pkg::NOUT;
    localparam int N_OUT = ((IMG_H - 1) / STRIDE + 1) * ((IMG_W - 1) / STRIDE + 1);
    localparam int MIN_IDLE = IMG_W + 4;
    localparam int MAX_GAP = 3;
    localparam int N_FRAMES = 9;
    // Worst case per frame is every pixel followed by the longest gap
    localparam int WATCH_CYCLES = N_FRAMES * (IMG_W * IMG_H * (MAX_GAP + 1) + IMG_W + 20) + 50;
    localparam int DRAIN_LIMIT = 2 * (IMG_W + 20);
    localparam int SETTLE = IMG_W + 8;

    typedef int frame_t [IMG_H][IMG_W][NCH];

    logic                    clk;
    logic                    rstn;
    logic                    in_valid;
    logic [NCH*ACT_W-1:0]    in_pix;
    logic                    out_valid;
    logic [NOUT*ACT_W-1:0]   out_pix;

    integer                  seed = 32'h1e28_9dd3;
    frame_t                  cur;
    logic [NOUT*ACT_W-1:0]   expq [$];
    logic [NOUT*ACT_W-1:0]   expv;
    logic                    check_en;
    int                      err_count;
    int                      err_start;
    int                      check_count;
    int                      got_count;
    int                      test_count;

    ds_block_top #(
        .IMG_W  (IMG_W),
        .IMG_H  (IMG_H),
        .STRIDE (STRIDE)
    ) u_ds_block_top (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_pix    (in_pix),
        .out_valid (out_valid),
        .out_pix   (out_pix)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Shift, ReLU, then saturate to the positive activation range
    function automatic int scale_act(input longint acc);
        longint v;
        v = acc >>> ds_pkg::FRAC_BITS;
        if (v < 0) begin
            return 0;
        end
        if (v > 32767) begin
            return 32767;
        end
        return int'(v);
    endfunction

    function automatic void model_frame(input frame_t f);
        int dwv [NCH];
        longint acc;
        int rr;
        int cc;
        int px;
        logic [NOUT*ACT_W-1:0] word;
        for (int r = 0; r < IMG_H; r += STRIDE) begin
            for (int c = 0; c < IMG_W; c += STRIDE) begin
                for (int ch = 0; ch < NCH; ch++) begin
                    acc = 0;
                    for (int k = 0; k < 9; k++) begin
                        rr = r + k / 3 - 1;
                        cc = c + k % 3 - 1;
                        px = (rr >= 0 && rr < IMG_H && cc >= 0 && cc < IMG_W) ? f[rr][cc][ch] : 0;
                        acc += longint'(px) * longint'(ds_pkg::dw_weight(ch, k));
                    end
                    dwv[ch] = scale_act(acc);
                end
                for (int o = 0; o < NOUT; o++) begin
                    acc = 0;
                    for (int ch = 0; ch < NCH; ch++) begin
                        acc += longint'(dwv[ch]) * longint'(ds_pkg::pw_weight(o, ch));
                    end
                    word[o*ACT_W +: ACT_W] = ACT_W'(scale_act(acc));
                end
                expq.push_back(word);
            end
        end
    endfunction

    task automatic fill_frame(input bit use_random, input int value);
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                for (int ch = 0; ch < NCH; ch++) begin
                    cur[r][c][ch] = use_random ? ($random(seed) % 2001) : value;
                end
            end
        end
    endtask

    task automatic send_frame(input frame_t f, input int max_gap, input int npix);
        int gap;
        logic [NCH*ACT_W-1:0] word;
        for (int i = 0; i < npix; i++) begin
            for (int ch = 0; ch < NCH; ch++) begin
                word[ch*ACT_W +: ACT_W] = ACT_W'(f[i / IMG_W][i % IMG_W][ch]);
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_pix   <= word;
            gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic finish_test(input string name, input int exp_count);
        int waited;
        waited = 0;
        while (expq.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        // Extra cycles catch any output beyond the last expected one
        repeat (SETTLE) @(posedge clk);
        if (expq.size() != 0) begin
            $display("%s: %0d expected outputs never appeared", name, expq.size());
            err_count++;
            expq.delete();
        end
        if (got_count != exp_count) begin
            $display("FAILED at %0t: %s gave %0d outputs instead of %0d",
                     $time, name, got_count, exp_count);
            err_count++;
        end
        test_count++;
        $display("Test %0d %s finished with %0d errors", test_count, name, err_count - err_start);
        err_start = err_count;
        got_count = 0;
    endtask

    always @(negedge clk) begin
        if (out_valid && check_en) begin
            got_count++;
            if (expq.size() == 0) begin
                $display("Output at time %0t arrived with no expected value left", $time);
                err_count++;
            end else begin
                expv = expq.pop_front();
                check_count++;
                if (out_pix !== expv) begin
                    $display("FAILED at %0t: out_pix %h, expected %h", $time, out_pix, expv);
                    err_count++;
                end
            end
        end
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the tests did not complete", WATCH_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rstn        = 1'b0;
        in_valid    = 1'b0;
        in_pix      = '0;
        check_en    = 1'b1;
        err_count   = 0;
        err_start   = 0;
        check_count = 0;
        got_count   = 0;
        test_count  = 0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        idle(2);

        fill_frame(1'b1, 0);
        model_frame(cur);
        send_frame(cur, 0, IMG_W * IMG_H);
        finish_test("random_frame", N_OUT);

        fill_frame(1'b0, 0);
        model_frame(cur);
        send_frame(cur, 0, IMG_W * IMG_H);
        finish_test("zero_frame", N_OUT);

        fill_frame(1'b0, 32767);
        model_frame(cur);
        send_frame(cur, 0, IMG_W * IMG_H);
        idle(MIN_IDLE - 1);
        fill_frame(1'b0, -32768);
        model_frame(cur);
        send_frame(cur, 0, IMG_W * IMG_H);
        finish_test("saturation", 2 * N_OUT);

        // One frame with gaps, then two frames at the minimum idle spacing
        fill_frame(1'b1, 0);
        model_frame(cur);
        send_frame(cur, MAX_GAP, IMG_W * IMG_H);
        for (int i = 0; i < 2; i++) begin
            idle(MIN_IDLE - 1);
            fill_frame(1'b1, 0);
            model_frame(cur);
            send_frame(cur, 0, IMG_W * IMG_H);
        end
        finish_test("gaps_back_to_back", 3 * N_OUT);

        check_en <= 1'b0;
        fill_frame(1'b1, 0);
        send_frame(cur, 0, IMG_W * IMG_H / 2);
        rstn <= 1'b0;
        repeat (2) @(posedge clk);
        check_en  = 1'b1;
        got_count = 0;
        rstn <= 1'b1;
        idle(MIN_IDLE);
        fill_frame(1'b1, 0);
        model_frame(cur);
        send_frame(cur, 0, IMG_W * IMG_H);
        finish_test("reset_mid_frame", N_OUT);

        $display("Tests: %0d, outputs compared: %0d, errors: %0d",
                 test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/ds_block_top.sv
`timescale 1ns/1ps
`default_nettype none

module ds_block_top #(
    parameter int IMG_W  = 6,
    parameter int IMG_H  = 5,
    parameter int STRIDE = 1
) (
    input  wire                                    clk,
    input  wire                                    rstn,
    input  wire                                    in_valid,
    input  wire  [ds_pkg::NCH*ds_pkg::ACT_W-1:0]   in_pix,
    output logic                                   out_valid,
    output logic [ds_pkg::NOUT*ds_pkg::ACT_W-1:0]  out_pix
);

    localparam int PIX_W = ds_pkg::NCH * ds_pkg::ACT_W;
    localparam int WIN_W = PIX_W * ds_pkg::KER * ds_pkg::KER;
    localparam int OUT_W = ds_pkg::NOUT * ds_pkg::ACT_W;

    logic             pix_valid;
    logic [PIX_W-1:0] pix;
    logic             win_valid;
    logic [WIN_W-1:0] win;
    logic             dw_valid;
    logic [PIX_W-1:0] dw_act;
    logic             pw_valid;
    logic [OUT_W-1:0] pw_act;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pix_valid <= 1'b0;
            pix       <= '0;
        end else begin
            pix_valid <= in_valid;
            pix       <= in_pix;
        end
    end

    window_buffer #(
        .IMG_W  (IMG_W),
        .IMG_H  (IMG_H),
        .STRIDE (STRIDE)
    ) u_window_buffer (
        .clk       (clk),
        .rstn      (rstn),
        .pix_valid (pix_valid),
        .pix       (pix),
        .win_valid (win_valid),
        .win       (win)
    );

    dw_conv u_dw_conv (
        .clk       (clk),
        .rstn      (rstn),
        .win_valid (win_valid),
        .win       (win),
        .dw_valid  (dw_valid),
        .dw_act    (dw_act)
    );

    pw_conv u_pw_conv (
        .clk      (clk),
        .rstn     (rstn),
        .dw_valid (dw_valid),
        .dw_act   (dw_act),
        .pw_valid (pw_valid),
        .pw_act   (pw_act)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
            out_pix   <= '0;
        end else begin
            out_valid <= pw_valid;
            out_pix   <= pw_act;
        end
    end

endmodule

`default_nettype wire

// File: source/pw_conv.sv
`timescale 1ns/1ps
`default_nettype none

module pw_conv (
    input  wire                                    clk,
    input  wire                                    rstn,
    input  wire                                    dw_valid,
    input  wire  [ds_pkg::NCH*ds_pkg::ACT_W-1:0]   dw_act,
    output logic                                   pw_valid,
    output logic [ds_pkg::NOUT*ds_pkg::ACT_W-1:0]  pw_act
);

    localparam int ACT_W = ds_pkg::ACT_W;
    localparam int NCH   = ds_pkg::NCH;
    localparam int NOUT  = ds_pkg::NOUT;

    logic         prod_valid;
    ds_pkg::acc_t prod [NOUT][NCH];
    ds_pkg::acc_t sum [NOUT];

    // Every output channel sees every input channel
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prod_valid <= 1'b0;
            for (int o = 0; o < NOUT; o++) begin
                for (int c = 0; c < NCH; c++) begin
                    prod[o][c] <= '0;
                end
            end
        end else begin
            prod_valid <= dw_valid;
            for (int o = 0; o < NOUT; o++) begin
                for (int c = 0; c < NCH; c++) begin
                    prod[o][c] <= ds_pkg::acc_t'($signed(dw_act[c * ACT_W +: ACT_W]))
                                * ds_pkg::acc_t'(ds_pkg::pw_weight(o, c));
                end
            end
        end
    end

    always_comb begin
        for (int o = 0; o < NOUT; o++) begin
            sum[o] = '0;
            for (int c = 0; c < NCH; c++) begin
                sum[o] = sum[o] + prod[o][c];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pw_valid <= 1'b0;
            pw_act   <= '0;
        end else begin
            pw_valid <= prod_valid;
            for (int o = 0; o < NOUT; o++) begin
                pw_act[o * ACT_W +: ACT_W] <= ds_pkg::round_clip(sum[o]);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/dw_conv.sv
`timescale 1ns/1ps
`default_nettype none

module dw_conv (
    input  wire                                                   clk,
    input  wire                                                   rstn,
    input  wire                                                   win_valid,
    input  wire  [ds_pkg::NCH*ds_pkg::KER*ds_pkg::KER*ds_pkg::ACT_W-1:0] win,
    output logic                                                  dw_valid,
    output logic [ds_pkg::NCH*ds_pkg::ACT_W-1:0]                  dw_act
);

    localparam int ACT_W = ds_pkg::ACT_W;
    localparam int NCH   = ds_pkg::NCH;
    localparam int NTAP  = ds_pkg::KER * ds_pkg::KER;

    logic         prod_valid;
    ds_pkg::acc_t prod [NCH][NTAP];
    ds_pkg::acc_t sum [NCH];

    // Stage 1 multiplies every tap by its channel's own weight
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prod_valid <= 1'b0;
            for (int c = 0; c < NCH; c++) begin
                for (int k = 0; k < NTAP; k++) begin
                    prod[c][k] <= '0;
                end
            end
        end else begin
            prod_valid <= win_valid;
            for (int c = 0; c < NCH; c++) begin
                for (int k = 0; k < NTAP; k++) begin
                    prod[c][k] <= ds_pkg::acc_t'($signed(win[(c * NTAP + k) * ACT_W +: ACT_W]))
                                * ds_pkg::acc_t'(ds_pkg::dw_weight(c, k));
                end
            end
        end
    end

    always_comb begin
        for (int c = 0; c < NCH; c++) begin
            sum[c] = '0;
            for (int k = 0; k < NTAP; k++) begin
                sum[c] = sum[c] + prod[c][k];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dw_valid <= 1'b0;
            dw_act   <= '0;
        end else begin
            dw_valid <= prod_valid;
            for (int c = 0; c < NCH; c++) begin
                dw_act[c * ACT_W +: ACT_W] <= ds_pkg::round_clip(sum[c]);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/window_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module window_buffer #(
    parameter int IMG_W  = 6,
    parameter int IMG_H  = 5,
    parameter int STRIDE = 1
) (
    input  wire                                                   clk,
    input  wire                                                   rstn,
    input  wire                                                   pix_valid,
    input  wire  [ds_pkg::NCH*ds_pkg::ACT_W-1:0]                  pix,
    output logic                                                  win_valid,
    output logic [ds_pkg::NCH*ds_pkg::KER*ds_pkg::KER*ds_pkg::ACT_W-1:0] win
);

    localparam int ACT_W = ds_pkg::ACT_W;
    localparam int PIX_W = ds_pkg::NCH * ACT_W;
    localparam int KER   = ds_pkg::KER;
    localparam int WIN_W = ds_pkg::NCH * KER * KER * ACT_W;
    localparam int CW    = $clog2(IMG_W + 1);
    localparam int RW    = $clog2(IMG_H + 2);

    ds_pkg::wb_state_t state;
    logic [CW-1:0]     wr_col;
    logic [RW-1:0]     wr_row;
    logic [PIX_W-1:0]  line0 [IMG_W];
    logic [PIX_W-1:0]  line1 [IMG_W];
    logic [PIX_W-1:0]  sw [KER][KER];
    logic [PIX_W-1:0]  nxt [KER][KER];
    logic [PIX_W-1:0]  wr_pix;
    logic              wr_en;
    logic              last_real;
    logic              last_drain;
    logic [RW-1:0]     cen_row;
    logic [CW-1:0]     cen_col;
    logic              row_ok;
    logic              stride_ok;
    logic              emit;
    logic              top_pad;
    logic              left_pad;
    logic              right_pad;
    logic [WIN_W-1:0]  win_d;

    // During the drain zero pixels stand in for the row below the image
    assign wr_en  = (state == ds_pkg::WB_DRAIN) || pix_valid;
    assign wr_pix = (state == ds_pkg::WB_DRAIN) ? '0 : pix;

    assign last_real  = (wr_row == RW'(IMG_H - 1)) && (wr_col == CW'(IMG_W - 1));
    assign last_drain = (wr_row == RW'(IMG_H + 1)) && (wr_col == '0);

    // A write at column 0 completes the right-edge window centred two rows up
    assign cen_row = (wr_col == '0) ? wr_row - RW'(2) : wr_row - RW'(1);
    assign cen_col = (wr_col == '0) ? CW'(IMG_W - 1) : wr_col - CW'(1);
    assign row_ok  = (wr_col == '0) ? (wr_row >= RW'(2)) : (wr_row != '0);

    assign stride_ok = ((int'(cen_row) % STRIDE) == 0) && ((int'(cen_col) % STRIDE) == 0);
    assign emit      = wr_en && row_ok && stride_ok;

    assign top_pad   = (cen_row == '0);
    assign left_pad  = (wr_col == CW'(1));
    assign right_pad = (wr_col == '0);

    // The window shifts left and takes the column {row-2, row-1, row} at wr_col
    always_comb begin
        for (int r = 0; r < KER; r++) begin
            nxt[r][0] = sw[r][1];
            nxt[r][1] = sw[r][2];
        end
        nxt[0][2] = line1[wr_col];
        nxt[1][2] = line0[wr_col];
        nxt[2][2] = wr_pix;
    end

    always_comb begin
        for (int ch = 0; ch < ds_pkg::NCH; ch++) begin
            for (int r = 0; r < KER; r++) begin
                for (int c = 0; c < KER; c++) begin
                    if ((r == 0 && top_pad) || (c == 0 && left_pad) ||
                        (c == KER - 1 && right_pad)) begin
                        win_d[((ch * KER + r) * KER + c) * ACT_W +: ACT_W] = '0;
                    end else begin
                        win_d[((ch * KER + r) * KER + c) * ACT_W +: ACT_W] =
                            nxt[r][c][ch * ACT_W +: ACT_W];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state  <= ds_pkg::WB_IDLE;
            wr_col <= '0;
            wr_row <= '0;
        end else begin
            case (state)
                ds_pkg::WB_IDLE: begin
                    if (pix_valid) begin
                        state <= ds_pkg::WB_RUN;
                    end
                end
                ds_pkg::WB_RUN: begin
                    if (pix_valid && last_real) begin
                        state <= ds_pkg::WB_DRAIN;
                    end
                end
                default: begin
                    if (last_drain) begin
                        state <= ds_pkg::WB_IDLE;
                    end
                end
            endcase
            if (wr_en) begin
                if (state == ds_pkg::WB_DRAIN && last_drain) begin
                    wr_col <= '0;
                    wr_row <= '0;
                end else if (wr_col == CW'(IMG_W - 1)) begin
                    wr_col <= '0;
                    wr_row <= wr_row + RW'(1);
                end else begin
                    wr_col <= wr_col + CW'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            line1[wr_col] <= line0[wr_col];
            line0[wr_col] <= wr_pix;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int r = 0; r < KER; r++) begin
                for (int c = 0; c < KER; c++) begin
                    sw[r][c] <= '0;
                end
            end
            win_valid <= 1'b0;
            win       <= '0;
        end else begin
            if (wr_en) begin
                sw <= nxt;
            end
            win_valid <= emit;
            if (emit) begin
                win <= win_d;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/ds_pkg.sv
`default_nettype none

package ds_pkg;

    localparam int ACT_W = 16;
    localparam int WGT_W = 8;
    localparam int ACC_W = 32;
    localparam int NCH = 2;
    localparam int NOUT = 4;
    // The window logic in window_buffer only handles a 3x3 kernel
    localparam int KER = 3;
    localparam int FRAC_BITS = 6;

    typedef logic signed [ACT_W-1:0] act_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_RUN,
        WB_DRAIN
    } wb_state_t;

    // Tap k runs 0..8 in raster order over the window
    function automatic logic signed [WGT_W-1:0] dw_weight(input int c, input int k);
        return WGT_W'(((c * KER * KER + k) * 37) % 15 - 7);
    endfunction

    function automatic logic signed [WGT_W-1:0] pw_weight(input int o, input int c);
        return WGT_W'(((o * NCH + c) * 23) % 13 - 6);
    endfunction

    // Fixed-point rescale followed by ReLU and saturation to the activation range
    function automatic act_t round_clip(input acc_t acc);
        acc_t shifted;
        shifted = acc >>> FRAC_BITS;
        if (shifted < 0) begin
            return '0;
        end
        if (shifted > 32767) begin
            return 16'sd32767;
        end
        return act_t'(shifted);
    endfunction

endpackage

`default_nettype wire
